//--- hdl/rvfi_pkg.sv
package rvfi_pkg;

	// datapath widths
	localparam int XLEN    = 32;		// register and pc width
	localparam int NREG    = 32;		// architectural registers x0..x31
	localparam int REG_AW  = $clog2(NREG);	// register index width
	localparam int ORDER_W = 16;		// retirement index and error counter width

	// one register value or pc
	typedef logic [XLEN-1:0] xlen_t;

	// register index as carried on rs1/rs2/rd
	typedef logic [REG_AW-1:0] reg_addr_t;

	// retirement index since reset, wraps around
	typedef logic [ORDER_W-1:0] order_t;

	// failing retirement count, saturates at all ones
	typedef logic [ORDER_W-1:0] count_t;

	// failure causes, pc causes rank above register causes
	typedef enum logic [2:0] {
		cause_none         = 3'd0,	// no failure
		cause_pc_jump      = 3'd1,	// pc_rdata differs from previous pc_wdata
		cause_pc_misalign  = 3'd2,	// next pc not word aligned
		cause_rs1_mismatch = 3'd3,	// rs1 value differs from shadow
		cause_rs2_mismatch = 3'd4,	// rs2 value differs from shadow
		cause_x0_write     = 3'd5	// nonzero value written to x0
	} fail_cause_t;

endpackage

//--- hdl/pc_flow_check.sv
`timescale 1ns/100ps

module pc_flow_check (
	input  logic                  clk,
	input  logic                  reset,

	// retirement port
	input  logic                  rvfi_valid,
	input  logic                  rvfi_trap,
	input  rvfi_pkg::xlen_t       rvfi_pc_rdata,	// address of retired instruction
	input  rvfi_pkg::xlen_t       rvfi_pc_wdata,	// address of next instruction

	// result, one cycle after the retirement
	output logic                  retired,
	output logic                  pc_fail,
	output rvfi_pkg::fail_cause_t pc_cause
);

	rvfi_pkg::xlen_t next_pc;	// pc_wdata of the last retirement
	logic            have_pc;	// next_pc holds a real value
	logic            pc_jump;
	logic            pc_misalign;

	// the first retirement after reset has nothing to compare against
	assign pc_jump = have_pc && (rvfi_pc_rdata != next_pc);

	// a trapping instruction reports the handler address, alignment not checked
	assign pc_misalign = !rvfi_trap && (rvfi_pc_wdata[1:0] != 2'b00);

	always_ff @(posedge clk) begin
		if (reset) begin
			retired  <= 1'b0;
			pc_fail  <= 1'b0;
			pc_cause <= rvfi_pkg::cause_none;
			have_pc  <= 1'b0;
		end else begin
			retired <= rvfi_valid;
			pc_fail <= rvfi_valid && (pc_jump || pc_misalign);
			if (rvfi_valid && pc_jump) begin
				pc_cause <= rvfi_pkg::cause_pc_jump;	// jump wins over misalign
			end else if (rvfi_valid && pc_misalign) begin
				pc_cause <= rvfi_pkg::cause_pc_misalign;
			end else begin
				pc_cause <= rvfi_pkg::cause_none;
			end
			if (rvfi_valid) begin
				have_pc <= 1'b1;
			end
		end
	end

	// traps store their next pc too, the handler entry is where flow continues
	always_ff @(posedge clk) begin
		if (rvfi_valid) begin
			next_pc <= rvfi_pc_wdata;
		end
	end

	// a failure is only ever reported for a retirement one cycle back
	a_fail_after_valid : assert property (
		@(posedge clk) disable iff (reset)
		pc_fail |-> $past(rvfi_valid)
	) else $error("pc_fail without a retirement in the previous cycle");

	// the report block picks the cause by pc_fail alone
	a_fail_has_cause : assert property (
		@(posedge clk) disable iff (reset)
		pc_fail |-> (pc_cause != rvfi_pkg::cause_none)
	) else $error("pc_fail raised with cause_none");

endmodule

//--- hdl/reg_shadow_check.sv
`timescale 1ns/100ps

module reg_shadow_check (
	input  logic                  clk,
	input  logic                  reset,

	// retirement port
	input  logic                  rvfi_valid,
	input  logic                  rvfi_trap,
	input  rvfi_pkg::reg_addr_t   rvfi_rs1_addr,
	input  rvfi_pkg::reg_addr_t   rvfi_rs2_addr,
	input  rvfi_pkg::reg_addr_t   rvfi_rd_addr,
	input  rvfi_pkg::xlen_t       rvfi_rs1_rdata,	// rs1 value before the instruction
	input  rvfi_pkg::xlen_t       rvfi_rs2_rdata,	// rs2 value before the instruction
	input  rvfi_pkg::xlen_t       rvfi_rd_wdata,	// rd value after the instruction

	// result, one cycle after the retirement
	output logic                  reg_fail,
	output rvfi_pkg::fail_cause_t reg_cause
);

	rvfi_pkg::xlen_t              shadow [rvfi_pkg::NREG];	// last value seen per register
	logic [rvfi_pkg::NREG-1:0]    known;			// shadow entry holds a real value
	logic                         retired_q;		// local copy of the valid strobe

	logic                         check_en;
	logic                         wr_en;
	logic                         rs1_bad;
	logic                         rs2_bad;
	logic                         x0_bad;
	rvfi_pkg::fail_cause_t        cause_next;

	// trapped instructions neither check nor update the file
	assign check_en = rvfi_valid && !rvfi_trap;
	assign wr_en    = check_en && (rvfi_rd_addr != '0);

	// reads compare against the file as it was before this retirement
	assign rs1_bad = known[rvfi_rs1_addr] && (shadow[rvfi_rs1_addr] != rvfi_rs1_rdata);
	assign rs2_bad = known[rvfi_rs2_addr] && (shadow[rvfi_rs2_addr] != rvfi_rs2_rdata);
	assign x0_bad  = (rvfi_rd_addr == '0) && (rvfi_rd_wdata != '0);

	always_comb begin
		if (rs1_bad) begin
			cause_next = rvfi_pkg::cause_rs1_mismatch;
		end else if (rs2_bad) begin
			cause_next = rvfi_pkg::cause_rs2_mismatch;
		end else if (x0_bad) begin
			cause_next = rvfi_pkg::cause_x0_write;
		end else begin
			cause_next = rvfi_pkg::cause_none;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_fail  <= 1'b0;
			reg_cause <= rvfi_pkg::cause_none;
			retired_q <= 1'b0;
		end else begin
			retired_q <= rvfi_valid;
			reg_fail  <= check_en && (cause_next != rvfi_pkg::cause_none);
			reg_cause <= check_en ? cause_next : rvfi_pkg::cause_none;
		end
	end

	// only x0 survives reset as known
	always_ff @(posedge clk) begin
		if (reset) begin
			known <= rvfi_pkg::NREG'(1);
		end else if (wr_en) begin
			known[rvfi_rd_addr] <= 1'b1;
		end
	end

	// x0 is loaded with zero at reset and never written afterwards
	always_ff @(posedge clk) begin
		if (reset) begin
			shadow[0] <= '0;
		end else if (wr_en) begin
			shadow[rvfi_rd_addr] <= rvfi_rd_wdata;
		end
	end

	a_x0_stable : assert property (
		@(posedge clk) disable iff (reset)
		known[0] && (shadow[0] == '0)
	) else $error("x0 shadow entry lost its known zero value");

	// fail must line up with the retirement it belongs to
	a_fail_after_valid : assert property (
		@(posedge clk) disable iff (reset)
		reg_fail |-> retired_q
	) else $error("reg_fail without a retirement in the previous cycle");

endmodule

//--- hdl/check_report.sv
`timescale 1ns/100ps

module check_report (
	input  logic                  clk,
	input  logic                  reset,

	// from the checkers, one cycle after the retirement
	input  logic                  retired,
	input  logic                  pc_fail,
	input  rvfi_pkg::fail_cause_t pc_cause,
	input  logic                  reg_fail,
	input  rvfi_pkg::fail_cause_t reg_cause,

	// per retirement report
	output logic                  fail,
	output rvfi_pkg::fail_cause_t fail_cause,
	output rvfi_pkg::order_t      fail_order,

	// run summary
	output logic                  error,
	output rvfi_pkg::fail_cause_t first_cause,
	output rvfi_pkg::count_t      err_count
);

	rvfi_pkg::order_t      order_q;	// index of the retirement now at the checker outputs
	logic                  any_fail;
	rvfi_pkg::fail_cause_t merged_cause;

	assign any_fail     = pc_fail || reg_fail;
	assign merged_cause = pc_fail ? pc_cause : reg_cause;	// pc faults rank first

	// retirement counter, wraps
	always_ff @(posedge clk) begin
		if (reset) begin
			order_q <= '0;
		end else if (retired) begin
			order_q <= order_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			fail       <= 1'b0;
			fail_cause <= rvfi_pkg::cause_none;
			fail_order <= '0;
		end else begin
			fail       <= any_fail;
			fail_cause <= any_fail ? merged_cause : rvfi_pkg::cause_none;
			if (any_fail) begin
				fail_order <= order_q;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			error       <= 1'b0;
			first_cause <= rvfi_pkg::cause_none;
			err_count   <= '0;
		end else if (any_fail) begin
			error <= 1'b1;
			if (!error) begin
				first_cause <= merged_cause;	// only the first one is kept
			end
			if (err_count != '1) begin
				err_count <= err_count + 1'b1;	// saturate at max
			end
		end
	end

	a_count_monotonic : assert property (
		@(posedge clk) disable iff (reset)
		!$past(reset) |-> (err_count >= $past(err_count))
	) else $error("err_count decreased without reset");

	a_error_sticky : assert property (
		@(posedge clk) disable iff (reset)
		error |=> error
	) else $error("error dropped without reset");

endmodule

//--- hdl/rvfi_monitor.sv
`timescale 1ns/100ps

module rvfi_monitor (
	input  logic                  clk,
	input  logic                  reset,

	// retirement port from the core
	input  logic                  rvfi_valid,
	input  logic                  rvfi_trap,
	input  rvfi_pkg::xlen_t       rvfi_pc_rdata,
	input  rvfi_pkg::xlen_t       rvfi_pc_wdata,
	input  rvfi_pkg::reg_addr_t   rvfi_rs1_addr,
	input  rvfi_pkg::xlen_t       rvfi_rs1_rdata,
	input  rvfi_pkg::reg_addr_t   rvfi_rs2_addr,
	input  rvfi_pkg::xlen_t       rvfi_rs2_rdata,
	input  rvfi_pkg::reg_addr_t   rvfi_rd_addr,
	input  rvfi_pkg::xlen_t       rvfi_rd_wdata,

	// report, two cycles after the retirement
	output logic                  fail,
	output rvfi_pkg::fail_cause_t fail_cause,
	output rvfi_pkg::order_t      fail_order,
	output logic                  error,
	output rvfi_pkg::fail_cause_t first_cause,
	output rvfi_pkg::count_t      err_count
);

	logic                  retired;
	logic                  pc_fail;
	rvfi_pkg::fail_cause_t pc_cause;
	logic                  reg_fail;
	rvfi_pkg::fail_cause_t reg_cause;

	pc_flow_check u_pc_flow (
		.clk			(clk),
		.reset			(reset),
		.rvfi_valid		(rvfi_valid),
		.rvfi_trap		(rvfi_trap),
		.rvfi_pc_rdata	(rvfi_pc_rdata),
		.rvfi_pc_wdata	(rvfi_pc_wdata),
		.retired		(retired),
		.pc_fail		(pc_fail),
		.pc_cause		(pc_cause)
	);

	reg_shadow_check u_reg_shadow (
		.clk			(clk),
		.reset			(reset),
		.rvfi_valid		(rvfi_valid),
		.rvfi_trap		(rvfi_trap),
		.rvfi_rs1_addr	(rvfi_rs1_addr),
		.rvfi_rs2_addr	(rvfi_rs2_addr),
		.rvfi_rd_addr	(rvfi_rd_addr),
		.rvfi_rs1_rdata	(rvfi_rs1_rdata),
		.rvfi_rs2_rdata	(rvfi_rs2_rdata),
		.rvfi_rd_wdata	(rvfi_rd_wdata),
		.reg_fail		(reg_fail),
		.reg_cause		(reg_cause)
	);

	check_report u_report (
		.clk			(clk),
		.reset			(reset),
		.retired		(retired),
		.pc_fail		(pc_fail),
		.pc_cause		(pc_cause),
		.reg_fail		(reg_fail),
		.reg_cause		(reg_cause),
		.fail			(fail),
		.fail_cause		(fail_cause),
		.fail_order		(fail_order),
		.error			(error),
		.first_cause	(first_cause),
		.err_count		(err_count)
	);

endmodule

//--- test/rvfi_scoreboard.sv
`timescale 1ns/100ps

module rvfi_scoreboard (
	input  logic                  clk,
	input  logic                  reset,

	// expectation for the retirement driven in the same cycle
	input  logic                  exp_fail,
	input  rvfi_pkg::fail_cause_t exp_cause,
	input  rvfi_pkg::order_t      exp_order,

	// run summary, compared while check_sum is high
	input  logic                  check_sum,
	input  logic                  sum_error,
	input  rvfi_pkg::fail_cause_t sum_first,
	input  rvfi_pkg::count_t      sum_count,
	input  logic                  run_done,

	// DUT report outputs
	input  logic                  fail,
	input  rvfi_pkg::fail_cause_t fail_cause,
	input  rvfi_pkg::order_t      fail_order,
	input  logic                  error,
	input  rvfi_pkg::fail_cause_t first_cause,
	input  rvfi_pkg::count_t      err_count,

	output int                    errors
);

	logic                  fail_q  [2];	// one stage per cycle of DUT latency
	rvfi_pkg::fail_cause_t cause_q [2];
	rvfi_pkg::order_t      order_q [2];
	int                    value_errs  = 0;
	int                    strobe_errs = 0;

	assign errors = value_errs + strobe_errs;

	always @(posedge clk) begin
		if (reset) begin
			fail_q[0]  <= 1'b0;
			fail_q[1]  <= 1'b0;
			cause_q[0] <= rvfi_pkg::cause_none;
			cause_q[1] <= rvfi_pkg::cause_none;
		end else begin
			// outputs read here were set one edge ago, the oldest stage matches them
			if (fail !== fail_q[1]) begin
				strobe_errs++;
				if (fail_q[1])
					$display("missing fail strobe for retirement %0d", order_q[1]);
				else
					$display("unexpected fail strobe, DUT index %0d", fail_order);
			end else begin
				if (fail_cause !== cause_q[1]) begin
					value_errs++;
					$display("Fail fail_cause: expected %h, got %h", cause_q[1], fail_cause);
				end
				if (fail && (fail_order !== order_q[1])) begin
					value_errs++;
					$display("Fail fail_order: expected %h, got %h", order_q[1], fail_order);
				end
			end
			fail_q[0]  <= exp_fail;
			fail_q[1]  <= fail_q[0];
			cause_q[0] <= exp_cause;
			cause_q[1] <= cause_q[0];
			order_q[0] <= exp_order;
			order_q[1] <= order_q[0];
		end
		if (check_sum) begin
			if (error !== sum_error) begin
				value_errs++;
				$display("Fail error: expected %h, got %h", sum_error, error);
			end
			if (first_cause !== sum_first) begin
				value_errs++;
				$display("Fail first_cause: expected %h, got %h", sum_first, first_cause);
			end
			if (err_count !== sum_count) begin
				value_errs++;
				$display("Fail err_count: expected %h, got %h", sum_count, err_count);
			end
		end
		if (run_done)
			$display("scoreboard: %0d errors (%0d wrong values, %0d strobe errors)",
				value_errs + strobe_errs, value_errs, strobe_errs);
	end

endmodule

//--- test/tb_rvfi_monitor.sv
`timescale 1ns/100ps

module tb_rvfi_monitor;

	localparam int N_RANDOM   = 200;	// clean random retirements
	localparam int N_DIRECTED = 17;	// directed retirements, phases two and three
	localparam int N_TOTAL    = N_RANDOM + N_DIRECTED;
	localparam int MAX_CYCLES = N_TOTAL * 4 + 100;	// gap of up to 3 plus drain

	logic                  clk;
	logic                  reset;
	logic                  rvfi_valid;
	logic                  rvfi_trap;
	rvfi_pkg::xlen_t       rvfi_pc_rdata;
	rvfi_pkg::xlen_t       rvfi_pc_wdata;
	rvfi_pkg::reg_addr_t   rvfi_rs1_addr;
	rvfi_pkg::xlen_t       rvfi_rs1_rdata;
	rvfi_pkg::reg_addr_t   rvfi_rs2_addr;
	rvfi_pkg::xlen_t       rvfi_rs2_rdata;
	rvfi_pkg::reg_addr_t   rvfi_rd_addr;
	rvfi_pkg::xlen_t       rvfi_rd_wdata;
	logic                  fail;
	rvfi_pkg::fail_cause_t fail_cause;
	rvfi_pkg::order_t      fail_order;
	logic                  error;
	rvfi_pkg::fail_cause_t first_cause;
	rvfi_pkg::count_t      err_count;

	logic                  exp_fail;	// expectation stream to the scoreboard
	rvfi_pkg::fail_cause_t exp_cause;
	rvfi_pkg::order_t      exp_order;
	logic                  check_sum;
	logic                  sum_error;
	rvfi_pkg::fail_cause_t sum_first;
	rvfi_pkg::count_t      sum_count;
	logic                  run_done;
	int                    errors;

	rvfi_pkg::xlen_t       shadow_ref [rvfi_pkg::NREG];	// reference register file
	logic [31:0]           known_ref;
	rvfi_pkg::xlen_t       next_pc_ref;
	logic                  have_pc_ref;
	rvfi_pkg::order_t      order_ref;
	logic                  error_ref;
	rvfi_pkg::fail_cause_t first_ref;
	rvfi_pkg::count_t      count_ref;

	rvfi_monitor u_dut (.*);

	rvfi_scoreboard u_check (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic void clear_model();
		known_ref     = 32'h1;	// x0 only
		shadow_ref[0] = '0;
		have_pc_ref   = 1'b0;
		order_ref     = '0;
		error_ref     = 1'b0;
		first_ref     = rvfi_pkg::cause_none;
		count_ref     = '0;
	endfunction

	function automatic rvfi_pkg::fail_cause_t expected_cause(input logic trap,
		input rvfi_pkg::xlen_t pc_r, input rvfi_pkg::xlen_t pc_w,
		input rvfi_pkg::reg_addr_t rs1, input rvfi_pkg::reg_addr_t rs2,
		input rvfi_pkg::reg_addr_t rd, input rvfi_pkg::xlen_t rs1_d,
		input rvfi_pkg::xlen_t rs2_d, input rvfi_pkg::xlen_t rd_d);
		if (have_pc_ref && (pc_r != next_pc_ref))
			return rvfi_pkg::cause_pc_jump;
		if (!trap && (pc_w % 4 != 0))
			return rvfi_pkg::cause_pc_misalign;
		if (trap)
			return rvfi_pkg::cause_none;	// traps skip register checks
		if (known_ref[rs1] && (shadow_ref[rs1] != rs1_d))
			return rvfi_pkg::cause_rs1_mismatch;
		if (known_ref[rs2] && (shadow_ref[rs2] != rs2_d))
			return rvfi_pkg::cause_rs2_mismatch;
		if ((rd == 0) && (rd_d != 0))
			return rvfi_pkg::cause_x0_write;
		return rvfi_pkg::cause_none;
	endfunction

	task automatic retire(input logic trap, input rvfi_pkg::xlen_t pc_r,
		input rvfi_pkg::xlen_t pc_w, input rvfi_pkg::reg_addr_t rs1,
		input rvfi_pkg::reg_addr_t rs2, input rvfi_pkg::reg_addr_t rd,
		input rvfi_pkg::xlen_t rs1_d, input rvfi_pkg::xlen_t rs2_d,
		input rvfi_pkg::xlen_t rd_d);
		rvfi_pkg::fail_cause_t cause;
		cause = expected_cause(trap, pc_r, pc_w, rs1, rs2, rd, rs1_d, rs2_d, rd_d);
		@(posedge clk);
		rvfi_valid     <= 1'b1;
		rvfi_trap      <= trap;
		rvfi_pc_rdata  <= pc_r;
		rvfi_pc_wdata  <= pc_w;
		rvfi_rs1_addr  <= rs1;
		rvfi_rs2_addr  <= rs2;
		rvfi_rd_addr   <= rd;
		rvfi_rs1_rdata <= rs1_d;
		rvfi_rs2_rdata <= rs2_d;
		rvfi_rd_wdata  <= rd_d;
		exp_fail       <= (cause != rvfi_pkg::cause_none);
		exp_cause      <= cause;
		exp_order      <= order_ref;
		if (cause != rvfi_pkg::cause_none) begin
			if (!error_ref)
				first_ref = cause;
			error_ref = 1'b1;
			if (count_ref != '1)
				count_ref = count_ref + 16'd1;
		end
		order_ref   = order_ref + 16'd1;
		have_pc_ref = 1'b1;
		next_pc_ref = pc_w;	// trap handler address counts as next pc
		if (!trap && (rd != 0)) begin
			shadow_ref[rd] = rd_d;
			known_ref[rd]  = 1'b1;
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			rvfi_valid <= 1'b0;
			exp_fail   <= 1'b0;
			exp_cause  <= rvfi_pkg::cause_none;
		end
	endtask

	task automatic random_step();
		rvfi_pkg::xlen_t     pc_r;
		rvfi_pkg::xlen_t     pc_w;
		rvfi_pkg::reg_addr_t rs1;
		rvfi_pkg::reg_addr_t rs2;
		rvfi_pkg::reg_addr_t rd;
		int                  gap;
		pc_r = have_pc_ref ? next_pc_ref : 32'h0000_1000;
		pc_w = ($urandom % 4 == 0) ? ($urandom & 32'hffff_fffc) : pc_r + 32'd4;
		rs1  = rvfi_pkg::reg_addr_t'($urandom % 32);
		rs2  = rvfi_pkg::reg_addr_t'($urandom % 32);
		rd   = rvfi_pkg::reg_addr_t'($urandom % 24);	// x24..x31 stay unwritten
		retire(1'b0, pc_r, pc_w, rs1, rs2, rd,
			known_ref[rs1] ? shadow_ref[rs1] : $urandom,
			known_ref[rs2] ? shadow_ref[rs2] : $urandom,
			(rd == 0) ? 32'h0 : $urandom);
		gap = $urandom % 4;
		if (gap != 0)
			idle(gap);
	endtask

	task automatic check_summary();
		@(posedge clk);
		check_sum <= 1'b1;
		sum_error <= error_ref;
		sum_first <= first_ref;
		sum_count <= count_ref;
		@(posedge clk);
		check_sum <= 1'b0;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset      <= 1'b1;
		rvfi_valid <= 1'b0;
		exp_fail   <= 1'b0;
		exp_cause  <= rvfi_pkg::cause_none;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		clear_model();
	endtask

	initial begin
		void'($urandom(32'h430));
		reset          = 1'b1;
		rvfi_valid     = 1'b0;
		rvfi_trap      = 1'b0;
		rvfi_pc_rdata  = '0;
		rvfi_pc_wdata  = '0;
		rvfi_rs1_addr  = '0;
		rvfi_rs1_rdata = '0;
		rvfi_rs2_addr  = '0;
		rvfi_rs2_rdata = '0;
		rvfi_rd_addr   = '0;
		rvfi_rd_wdata  = '0;
		exp_fail       = 1'b0;
		exp_cause      = rvfi_pkg::cause_none;
		exp_order      = '0;
		check_sum      = 1'b0;
		sum_error      = 1'b0;
		sum_first      = rvfi_pkg::cause_none;
		sum_count      = '0;
		run_done       = 1'b0;
		clear_model();
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		repeat (N_RANDOM) random_step();	// clean program, error must stay low
		idle(4);
		check_summary();

		// pc faults, back to back
		retire(0, next_pc_ref + 8, next_pc_ref + 12, 0, 0, 0, 0, 0, 0);
		retire(0, next_pc_ref, next_pc_ref + 2, 0, 0, 0, 0, 0, 0);
		retire(0, next_pc_ref + 4, next_pc_ref + 5, 0, 0, 0, 0, 0, 0);	// jump and misalign
		retire(1, next_pc_ref, next_pc_ref + 6, 0, 0, 0, 0, 0, 0);
		retire(0, next_pc_ref, (next_pc_ref & 32'hffff_fffc) + 8, 0, 0, 0, 0, 0, 0);
		// register faults
		retire(0, next_pc_ref, next_pc_ref + 4, 0, 0, 5, 0, 0, 32'ha5a5_0001);
		retire(0, next_pc_ref, next_pc_ref + 4, 5, 5, 0,
			shadow_ref[5] ^ 32'h1, shadow_ref[5] ^ 32'h2, 0);
		retire(0, next_pc_ref, next_pc_ref + 4, 0, 5, 0, 0, shadow_ref[5] ^ 32'h4, 0);
		retire(0, next_pc_ref, next_pc_ref + 4, 30, 31, 0, $urandom, $urandom, 0);
		retire(0, next_pc_ref, next_pc_ref + 4, 0, 0, 0, 0, 0, 32'h1);
		retire(1, next_pc_ref, 32'h0000_0100, 5, 5, 5,
			shadow_ref[5] ^ 32'h8, shadow_ref[5] ^ 32'h8, 32'hdead_beef);
		retire(0, 32'h0000_0100, 32'h0000_0104, 5, 0, 0, shadow_ref[5], 0, 0);
		retire(0, next_pc_ref + 16, next_pc_ref + 20, 5, 0, 0, shadow_ref[5] ^ 32'h1, 0, 0);
		idle(4);
		check_summary();

		// reset mid run, then index 3 carries a jump
		apply_reset();
		retire(0, 32'h4000_0000, 32'h4000_0004, 0, 0, 0, 0, 0, 0);
		random_step();
		random_step();
		retire(0, next_pc_ref + 4, next_pc_ref + 8, 0, 0, 0, 0, 0, 0);
		idle(4);
		check_summary();

		@(posedge clk);
		run_done <= 1'b1;
		@(posedge clk);
		run_done <= 1'b0;
		@(negedge clk);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		repeat (MAX_CYCLES) @(posedge clk);
		$display("timeout: run still busy after %0d clock cycles", MAX_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- src.f
hdl/rvfi_pkg.sv
hdl/pc_flow_check.sv
hdl/reg_shadow_check.sv
hdl/check_report.sv
hdl/rvfi_monitor.sv
test/rvfi_scoreboard.sv
test/tb_rvfi_monitor.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_rvfi_monitor
FILELIST = src.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check for the pass line"
	@echo "  clean  remove the build directory $(BUILD)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	@out=$$(./$(BUILD)/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(BUILD)
